// ==== Bender.yml ====
package:
  name: rv32_csr_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv32_csr_req_pkg.sv
      - rtl/rv32_csr_state_pkg.sv
      - rtl/rv32_machine_regs.sv
      - rtl/rv32_perf_counters.sv
      - rtl/rv32_csr_access.sv
      - rtl/rv32_csr_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/clock_gen.sv
      - bench/rv32_csr_unit_tb.sv

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0; // released off the edge, like the other inputs.
    end

endmodule

// ==== bench/rv32_csr_unit_tb.sv ====
`timescale 1ns/1ps

`include "rv32_csr_params.svh"

module rv32_csr_unit_tb
    import rv32_csr_req_pkg::*;
();

    logic         clk;
    logic         reset;
    logic         stall;
    logic         instr_retired;
    csr_request_t request;
    logic [31:0]  read_value;
    logic         illegal;

    logic        m_mie, m_mpie, m_inh_cy, m_inh_ir;
    logic [31:0] m_mscratch, m_mtvec, m_mepc, m_mcause;
    logic [63:0] m_cycle, m_instret;
    logic [31:0] exp_read, src, new_value;
    logic        exp_known, exp_illegal;
    int          read_errors = 0;
    int          illegal_errors = 0;
    int          timeouts = 0;
    int          requests = 0;

    clock_gen clocks (.clk(clk), .reset(reset));

    rv32_csr_unit uut (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .request       (request),
        .instr_retired (instr_retired),
        .read_value    (read_value),
        .illegal       (illegal)
    );

    function automatic logic in_zero_space(logic [11:0] a);
        return (a >= `RV32_CSR_MHPMEVENT_BASE && a <= `RV32_CSR_MHPMEVENT_LAST) ||
               (a >= `RV32_CSR_MHPMCOUNTER_BASE && a <= `RV32_CSR_MHPMCOUNTER_LAST) ||
               (a >= `RV32_CSR_MHPMCOUNTERH_BASE && a <= `RV32_CSR_MHPMCOUNTERH_LAST) ||
               (a >= `RV32_CSR_PMPCFG_BASE && a <= `RV32_CSR_PMPCFG_LAST) ||
               (a >= `RV32_CSR_PMPADDR_BASE && a <= `RV32_CSR_PMPADDR_LAST) ||
               (a >= `RV32_CSR_MVENDORID && a <= `RV32_CSR_MHARTID);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    always_comb begin
        exp_known = 1'b1;
        case (request.addr)
            `RV32_CSR_MSTATUS:  exp_read = 32'h1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
            `RV32_CSR_MISA:     exp_read = 32'h4000_1100; // RV32 with I and M.
            `RV32_CSR_MTVEC:    exp_read = m_mtvec;
            `RV32_CSR_MSCRATCH: exp_read = m_mscratch;
            `RV32_CSR_MEPC:     exp_read = m_mepc;
            `RV32_CSR_MCAUSE:   exp_read = m_mcause;
            `RV32_CSR_MCOUNTINHIBIT: exp_read = {29'b0, m_inh_ir, 1'b0, m_inh_cy};
            `RV32_CSR_MCYCLE, `RV32_CSR_CYCLE, `RV32_CSR_TIME: exp_read = m_cycle[31:0];
            `RV32_CSR_MCYCLEH, `RV32_CSR_CYCLEH, `RV32_CSR_TIMEH: exp_read = m_cycle[63:32];
            `RV32_CSR_MINSTRET, `RV32_CSR_INSTRET: exp_read = m_instret[31:0];
            `RV32_CSR_MINSTRETH, `RV32_CSR_INSTRETH: exp_read = m_instret[63:32];
            default: begin
                exp_read  = 32'b0;
                exp_known = in_zero_space(request.addr);
            end
        endcase
        exp_illegal = ((request.read || request.write) && !exp_known) ||
                      (request.write && request.addr[11:10] == 2'b11); // read-only space.
        src = (request.src == csr_src_reg) ? request.rs1_value : request.imm_value;
        case (request.write_op)
            csr_op_rs: new_value = exp_read | src;
            csr_op_rc: new_value = exp_read & ~src;
            default:   new_value = src;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            {m_mie, m_mpie, m_inh_cy, m_inh_ir} <= 4'b0;
            {m_mscratch, m_mtvec, m_mepc, m_mcause} <= 128'b0;
            m_cycle   <= 64'd0;
            m_instret <= 64'd0;
        end else begin
            if (request.read || request.write) requests <= requests + 1;
            if (!m_inh_cy) m_cycle <= m_cycle + 64'd1;
            if (!m_inh_ir && instr_retired) m_instret <= m_instret + 64'd1;
            if (request.write && !stall && !exp_illegal) begin
                case (request.addr)
                    `RV32_CSR_MSTATUS: begin
                        m_mie  <= new_value[3];
                        m_mpie <= new_value[7];
                    end
                    `RV32_CSR_MSCRATCH: m_mscratch <= new_value;
                    `RV32_CSR_MTVEC:    m_mtvec <= new_value & ~32'h3; // direct mode only.
                    `RV32_CSR_MEPC:     m_mepc <= new_value & ~32'h3;
                    `RV32_CSR_MCAUSE:   m_mcause <= new_value;
                    `RV32_CSR_MCOUNTINHIBIT: begin
                        m_inh_cy <= new_value[0];
                        m_inh_ir <= new_value[2];
                    end
                    default: ;
                endcase
            end
        end
    end

    read_check: assert property (@(posedge clk) disable iff (reset)
        (request.read || request.write) |-> read_value == exp_read)
    else begin
        read_errors++;
        $display("** Error at %0t: read_value = 0x%08h, expected 0x%08h (addr 0x%03h)",
                 $realtime, $sampled(read_value), $sampled(exp_read), $sampled(request.addr));
    end

    illegal_check: assert property (@(posedge clk) disable iff (reset) illegal == exp_illegal)
    else begin
        illegal_errors++;
        $display("** Error at %0t: illegal = %b, expected %b (addr 0x%03h)",
                 $realtime, $sampled(illegal), $sampled(exp_illegal), $sampled(request.addr));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    task automatic step();
        @(posedge clk);
        #1;
        instr_retired = 1'($urandom_range(0, 1));
    endtask

    task automatic csr_access(input logic rd, input logic wr, input csr_write_op_e op,
                              input csr_src_e src_sel, input logic [11:0] addr,
                              input logic [31:0] operand, input logic stall_on);
        request.read      = rd;
        request.write     = wr;
        request.write_op  = op;
        request.src       = src_sel;
        request.addr      = addr;
        request.rs1_value = (src_sel == csr_src_reg) ? operand : $urandom; // the unused one is noise.
        request.imm_value = (src_sel == csr_src_imm) ? operand : $urandom;
        stall             = stall_on;
        step();
    endtask

    task automatic read_csr(input logic [11:0] addr);
        csr_access(1'b1, 1'b0, csr_op_rw, csr_src_reg, addr, 32'b0, 1'b0);
    endtask

    task automatic write_csr(input csr_write_op_e op, input csr_src_e src_sel,
                             input logic [11:0] addr, input logic [31:0] operand);
        csr_access(1'b1, 1'b1, op, src_sel, addr, operand, 1'b0);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < 64) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            timeouts++;
            $display("reset was still asserted after %0d cycles", cycles);
        end
        #1;
    endtask

    task automatic finish_run();
        $display("%0d requests checked, %0d read_value errors, %0d illegal errors, %0d timeouts",
                 requests, read_errors, illegal_errors, timeouts);
        if (read_errors + illegal_errors + timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [11:0]   targets [4];
        csr_write_op_e op;
        csr_src_e      src_sel;
        logic [31:0]   operand;
        void'($urandom(1981));
        request       = '0;
        stall         = 1'b0;
        instr_retired = 1'b0;
        targets       = '{`RV32_CSR_MSCRATCH, `RV32_CSR_MEPC, `RV32_CSR_MTVEC, `RV32_CSR_MCAUSE};
        wait_reset_release();
        if (timeouts == 0) begin
            read_csr(`RV32_CSR_MSTATUS);
            read_csr(`RV32_CSR_MISA);
            foreach (targets[i]) read_csr(targets[i]);
            for (int i = 0; i < 48; i++) begin
                op      = csr_write_op_e'($urandom_range(0, 2));
                src_sel = csr_src_e'($urandom_range(0, 1));
                operand = (src_sel == csr_src_imm) ? 32'($urandom_range(0, 31)) : $urandom;
                write_csr(op, src_sel, targets[i % 4], operand);
                read_csr(targets[i % 4]);
            end
            write_csr(csr_op_rw, csr_src_reg, `RV32_CSR_MSTATUS, 32'hffff_ffff);
            read_csr(`RV32_CSR_MSTATUS); // MPP, MPIE and MIE only.
            write_csr(csr_op_rc, csr_src_imm, `RV32_CSR_MSTATUS, 32'h8);
            read_csr(`RV32_CSR_MSTATUS);
            csr_access(1'b1, 1'b1, csr_op_rw, csr_src_reg, `RV32_CSR_MSCRATCH, $urandom, 1'b1);
            csr_access(1'b1, 1'b0, csr_op_rw, csr_src_reg, `RV32_CSR_MSCRATCH, 32'b0, 1'b1);
            read_csr(`RV32_CSR_MSCRATCH);
            read_csr(`RV32_CSR_CYCLE);
            read_csr(`RV32_CSR_CYCLE);
            read_csr(`RV32_CSR_INSTRET);
            read_csr(`RV32_CSR_MINSTRETH);
            read_csr(`RV32_CSR_MCYCLEH);
            read_csr(`RV32_CSR_CYCLEH);
            read_csr(`RV32_CSR_TIME);
            write_csr(csr_op_rw, csr_src_imm, `RV32_CSR_MCOUNTINHIBIT, 32'h5);
            repeat (4) begin
                read_csr(`RV32_CSR_MCYCLE);
                read_csr(`RV32_CSR_MINSTRET);
            end
            write_csr(csr_op_rc, csr_src_imm, `RV32_CSR_MCOUNTINHIBIT, 32'h5);
            read_csr(`RV32_CSR_CYCLE);
            read_csr(`RV32_CSR_CYCLE);
            read_csr(12'h7C0);
            write_csr(csr_op_rw, csr_src_reg, 12'h7C0, $urandom);
            write_csr(csr_op_rw, csr_src_reg, `RV32_CSR_CYCLE, $urandom);
            read_csr(`RV32_CSR_CYCLE);
            write_csr(csr_op_rw, csr_src_reg, `RV32_CSR_MCYCLE, $urandom); // legal, ignored.
            write_csr(csr_op_rs, csr_src_reg, `RV32_CSR_MISA, 32'hffff_ffff);
            read_csr(`RV32_CSR_MISA);
            read_csr(12'hB05);
            read_csr(12'h3B2);
            read_csr(`RV32_CSR_MHARTID);
            foreach (targets[i]) read_csr(targets[i]);
            request = '0;
            repeat (2) step();
        end
        finish_run();
    end

endmodule

// ==== rtl/rv32_csr_access.sv ====
`timescale 1ns/1ps

`include "rv32_csr_params.svh"

module rv32_csr_access
    import rv32_csr_req_pkg::*;
    import rv32_csr_state_pkg::*;
(
    input  csr_request_t  request,
    input  logic          stall,
    input  machine_regs_t mregs,
    input  counters_t     counters,
    output logic [31:0]   read_value,
    output logic          illegal,
    output csr_write_t    write_cmd
);

    typedef enum logic [2:0] {
        cls_mreg,
        cls_counter,
        cls_const,
        cls_zero,
        cls_unknown
    } addr_class_e;

    addr_class_e  addr_class;
    csr_reg_sel_e mreg_sel;
    logic         is_mreg;
    logic         in_zero_range;
    logic [63:0]  counter_word;
    logic [31:0]  src_value;
    logic [31:0]  new_value;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    always_comb begin
        is_mreg  = 1'b1;
        mreg_sel = sel_mstatus;
        case (request.addr)
            `RV32_CSR_MSTATUS:       mreg_sel = sel_mstatus;
            `RV32_CSR_MSCRATCH:      mreg_sel = sel_mscratch;
            `RV32_CSR_MTVEC:         mreg_sel = sel_mtvec;
            `RV32_CSR_MEPC:          mreg_sel = sel_mepc;
            `RV32_CSR_MCAUSE:        mreg_sel = sel_mcause;
            `RV32_CSR_MCOUNTINHIBIT: mreg_sel = sel_countinhibit;
            default:                 is_mreg = 1'b0;
        endcase
    end

    assign in_zero_range =
        (request.addr >= `RV32_CSR_MHPMEVENT_BASE && request.addr <= `RV32_CSR_MHPMEVENT_LAST) ||
        (request.addr >= `RV32_CSR_MHPMCOUNTER_BASE &&
         request.addr <= `RV32_CSR_MHPMCOUNTER_LAST) ||
        (request.addr >= `RV32_CSR_MHPMCOUNTERH_BASE &&
         request.addr <= `RV32_CSR_MHPMCOUNTERH_LAST) ||
        (request.addr >= `RV32_CSR_PMPCFG_BASE && request.addr <= `RV32_CSR_PMPCFG_LAST) ||
        (request.addr >= `RV32_CSR_PMPADDR_BASE && request.addr <= `RV32_CSR_PMPADDR_LAST);

    always_comb begin
        case (request.addr)
            `RV32_CSR_MCYCLE, `RV32_CSR_MINSTRET, `RV32_CSR_MCYCLEH, `RV32_CSR_MINSTRETH,
            `RV32_CSR_CYCLE, `RV32_CSR_TIME, `RV32_CSR_INSTRET,
            `RV32_CSR_CYCLEH, `RV32_CSR_TIMEH, `RV32_CSR_INSTRETH: addr_class = cls_counter;
            `RV32_CSR_MISA: addr_class = cls_const;
            `RV32_CSR_MVENDORID, `RV32_CSR_MARCHID,
            `RV32_CSR_MIMPID, `RV32_CSR_MHARTID: addr_class = cls_zero;
            default: begin
                if (is_mreg) addr_class = cls_mreg;
                else if (in_zero_range) addr_class = cls_zero;
                else addr_class = cls_unknown;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read value
    assign counter_word = request.addr[1] ? counters.instret : counters.cycle; // time is cycle.

    always_comb begin
        case (addr_class)
            cls_mreg: begin
                case (mreg_sel)
                    sel_mstatus: read_value = {19'b0, `RV32_MSTATUS_MPP, 3'b0, mregs.mpie,
                                               3'b0, mregs.mie, 3'b0};
                    sel_mscratch:     read_value = mregs.mscratch;
                    sel_mtvec:        read_value = mregs.mtvec;
                    sel_mepc:         read_value = mregs.mepc;
                    sel_mcause:       read_value = mregs.mcause;
                    sel_countinhibit: read_value = {29'b0, counters.inhibit_ir, 1'b0,
                                                    counters.inhibit_cy};
                    default:          read_value = 32'b0;
                endcase
            end
            cls_counter: read_value = request.addr[7] ? counter_word[63:32] : counter_word[31:0];
            cls_const:   read_value = `RV32_MISA_VALUE;
            default:     read_value = 32'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path
    assign illegal = ((request.read || request.write) && addr_class == cls_unknown) ||
                     (request.write && request.addr[11:10] == 2'b11);

    assign src_value = (request.src == csr_src_reg) ? request.rs1_value : request.imm_value;

    always_comb begin
        case (request.write_op)
            csr_op_rw: new_value = src_value;
            csr_op_rs: new_value = read_value | src_value;
            csr_op_rc: new_value = read_value & ~src_value;
            default:   new_value = read_value; // unused encoding keeps the old value.
        endcase
    end

    assign write_cmd.en    = request.write && (addr_class == cls_mreg) && !stall && !illegal;
    assign write_cmd.sel   = mreg_sel;
    assign write_cmd.value = new_value;

endmodule

// ==== rtl/rv32_csr_params.svh ====
`ifndef RV32_CSR_PARAMS_SVH
`define RV32_CSR_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine-mode registers
`define RV32_CSR_MSTATUS         12'h300
`define RV32_CSR_MISA            12'h301
`define RV32_CSR_MTVEC           12'h305
`define RV32_CSR_MCOUNTINHIBIT   12'h320
`define RV32_CSR_MSCRATCH        12'h340
`define RV32_CSR_MEPC            12'h341
`define RV32_CSR_MCAUSE          12'h342

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counters, machine view and user aliases
`define RV32_CSR_MCYCLE          12'hB00
`define RV32_CSR_MINSTRET        12'hB02
`define RV32_CSR_MCYCLEH         12'hB80
`define RV32_CSR_MINSTRETH       12'hB82
`define RV32_CSR_CYCLE           12'hC00
`define RV32_CSR_TIME            12'hC01
`define RV32_CSR_INSTRET         12'hC02
`define RV32_CSR_CYCLEH          12'hC80
`define RV32_CSR_TIMEH           12'hC81
`define RV32_CSR_INSTRETH        12'hC82

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ranges that read as zero
`define RV32_CSR_MHPMEVENT_BASE    12'h323
`define RV32_CSR_MHPMEVENT_LAST    12'h33F
`define RV32_CSR_MHPMCOUNTER_BASE  12'hB03
`define RV32_CSR_MHPMCOUNTER_LAST  12'hB1F
`define RV32_CSR_MHPMCOUNTERH_BASE 12'hB83
`define RV32_CSR_MHPMCOUNTERH_LAST 12'hB9F
`define RV32_CSR_PMPCFG_BASE       12'h3A0
`define RV32_CSR_PMPCFG_LAST       12'h3A3
`define RV32_CSR_PMPADDR_BASE      12'h3B0
`define RV32_CSR_PMPADDR_LAST      12'h3BF

`define RV32_CSR_MVENDORID       12'hF11
`define RV32_CSR_MARCHID         12'hF12
`define RV32_CSR_MIMPID          12'hF13
`define RV32_CSR_MHARTID         12'hF14

// xlen field of 1 selects RV32, then one bit per extension from A to Z.
`define RV32_MISA_VALUE 32'b01_0000_00000000000001000100000000

`define RV32_MSTATUS_MPP 2'b11

`endif

// ==== rtl/rv32_csr_req_pkg.sv ====
package rv32_csr_req_pkg;

    typedef enum logic [1:0] {
        csr_op_rw = 2'b00,
        csr_op_rs = 2'b01,
        csr_op_rc = 2'b10
    } csr_write_op_e;

    typedef enum logic {
        csr_src_imm = 1'b0,
        csr_src_reg = 1'b1
    } csr_src_e;

    // targets of a write command inside the state parts.
    typedef enum logic [2:0] {
        sel_mstatus,
        sel_mscratch,
        sel_mtvec,
        sel_mepc,
        sel_mcause,
        sel_countinhibit
    } csr_reg_sel_e;

    typedef struct packed {
        logic          read;
        logic          write;
        csr_write_op_e write_op;
        csr_src_e      src;
        logic [11:0]   addr;
        logic [31:0]   rs1_value;
        logic [31:0]   imm_value;
    } csr_request_t;

endpackage

// ==== rtl/rv32_csr_state_pkg.sv ====
package rv32_csr_state_pkg;
    import rv32_csr_req_pkg::*;

    typedef struct packed {
        logic        mie;
        logic        mpie;
        logic [31:0] mscratch;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] mcause;
    } machine_regs_t;

    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] instret;
        logic        inhibit_cy;
        logic        inhibit_ir;
    } counters_t;

    typedef struct packed {
        logic         en;
        csr_reg_sel_e sel;
        logic [31:0]  value;
    } csr_write_t;

endpackage

// ==== rtl/rv32_csr_unit.sv ====
`timescale 1ns/1ps

module rv32_csr_unit
    import rv32_csr_req_pkg::*;
    import rv32_csr_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  csr_request_t request,
    input  logic         instr_retired,
    output logic [31:0]  read_value,
    output logic         illegal
);

    csr_write_t    write_cmd;
    machine_regs_t mregs;
    counters_t     counters;

    rv32_csr_access access (
        .request    (request),
        .stall      (stall),
        .mregs      (mregs),
        .counters   (counters),
        .read_value (read_value),
        .illegal    (illegal),
        .write_cmd  (write_cmd)
    );

    rv32_machine_regs machine_regs (
        .clk       (clk),
        .reset     (reset),
        .write_cmd (write_cmd),
        .mregs     (mregs)
    );

    rv32_perf_counters perf_counters (
        .clk           (clk),
        .reset         (reset),
        .instr_retired (instr_retired),
        .write_cmd     (write_cmd),
        .counters      (counters)
    );

endmodule

// ==== rtl/rv32_machine_regs.sv ====
`timescale 1ns/1ps

module rv32_machine_regs
    import rv32_csr_req_pkg::*;
    import rv32_csr_state_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  csr_write_t    write_cmd,
    output machine_regs_t mregs
);

    logic [31:0] aligned_value;

    assign aligned_value = {write_cmd.value[31:2], 2'b00}; // mtvec and mepc drop bits 1:0.

    always_ff @(posedge clk) begin
        if (reset) begin
            mregs <= '0;
        end else if (write_cmd.en) begin
            case (write_cmd.sel)
                sel_mstatus: begin
                    mregs.mie  <= write_cmd.value[3];
                    mregs.mpie <= write_cmd.value[7];
                end
                sel_mscratch: begin
                    mregs.mscratch <= write_cmd.value;
                end
                sel_mtvec: begin
                    mregs.mtvec <= aligned_value; // only direct mode is supported.
                end
                sel_mepc: begin
                    mregs.mepc <= aligned_value;
                end
                sel_mcause: begin
                    mregs.mcause <= write_cmd.value;
                end
                default: begin
                    // countinhibit lives in the counter block.
                end
            endcase
        end
    end

endmodule

// ==== rtl/rv32_perf_counters.sv ====
`timescale 1ns/1ps

module rv32_perf_counters
    import rv32_csr_req_pkg::*;
    import rv32_csr_state_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_retired,
    input  csr_write_t write_cmd,
    output counters_t  counters
);

    logic inhibit_write;

    assign inhibit_write = write_cmd.en && (write_cmd.sel == sel_countinhibit);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the counters step on the old inhibit bits at the edge that loads new ones.
    always_ff @(posedge clk) begin
        if (reset) begin
            counters <= '0;
        end else begin
            if (!counters.inhibit_cy) begin
                counters.cycle <= counters.cycle + 64'd1;
            end
            if (!counters.inhibit_ir) begin
                counters.instret <= counters.instret + 64'(instr_retired);
            end
            if (inhibit_write) begin
                counters.inhibit_cy <= write_cmd.value[0]; // bit 1 is time, which has no inhibit.
                counters.inhibit_ir <= write_cmd.value[2];
            end
        end
    end

endmodule

// ==== rv32_csr_unit.f ====
+incdir+rtl
rtl/rv32_csr_req_pkg.sv
rtl/rv32_csr_state_pkg.sv
rtl/rv32_machine_regs.sv
rtl/rv32_perf_counters.sv
rtl/rv32_csr_access.sv
rtl/rv32_csr_unit.sv
bench/clock_gen.sv
bench/rv32_csr_unit_tb.sv
